// ==== sim.f ====
+incdir+common
common/rs_pkg.sv
design/gf_mul.sv
chien/chien_cell.sv
chien/chien_ctrl.sv
chien/chien_search.sv
dv/tb_clk_gen.sv
dv/tb_chien.sv

// ==== Makefile ====
TOP := tb_chien

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f common/rs_config.svh common/rs_pkg.sv design/gf_mul.sv \
                 chien/chien_cell.sv chien/chien_ctrl.sv chien/chien_search.sv \
                 dv/tb_clk_gen.sv dv/tb_chien.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_chien.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_config.svh"

module tb_chien;
    import rs_pkg::*;

    localparam int NUM_BUILT      = 20;
    localparam int NUM_RANDOM     = 150;
    localparam int DONE_AT        = 17;      // negedges from start to done
    localparam int TIMEOUT_CYCLES = 10000;   // about 175 scans of 20 cycles each plus margin

    logic          clk;
    logic          rst_n;
    logic          start;
    lambda_t       lambda;
    chien_result_t result;
    logic          done;

    logic [31:0]   lfsr_state;
    chien_result_t exp_res;        // expectation for the scan in flight
    logic          pending;
    int            since_start;
    int            done_count;
    int            cycle_count;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(8)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    chien_search dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .lambda (lambda),
        .result (result),
        .done   (done)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // bit-serial product in GF(256)
    function automatic sym_t gf_mult(input sym_t a, input sym_t b);
        logic [8:0] x;
        sym_t       acc;
        x   = {1'b0, a};
        acc = '0;
        for (int k = 0; k < 8; k++) begin
            if (b[k]) begin
                acc = acc ^ x[7:0];
            end
            x = x << 1;
            if (x[8]) begin
                x = x ^ `RS_GF_POLY;
            end
        end
        return acc;
    endfunction

    function automatic sym_t alpha_to(input int k);
        sym_t v;
        v = 8'h01;
        for (int n = 0; n < k; n++) begin
            v = gf_mult(v, 8'h02);
        end
        return v;
    endfunction

    // l(x) * (x + r)
    function automatic lambda_t mul_linear(input lambda_t l, input sym_t r);
        lambda_t q;
        q.coef[0] = gf_mult(l.coef[0], r);
        for (int j = 1; j <= `RS_T; j++) begin
            q.coef[j] = l.coef[j-1] ^ gf_mult(l.coef[j], r);
        end
        return q;
    endfunction

    function automatic chien_result_t chien_ref(input lambda_t l);
        chien_result_t r;
        sym_t          x;
        sym_t          y;
        r.count = '0;
        r.loc   = {`RS_T{`RS_LOC_NONE}};
        x = 8'h01;
        for (int i = 0; i < `RS_N; i++) begin
            x = gf_mult(x, 8'h02);   // alpha^(i+1)
            y = '0;
            for (int j = `RS_T; j >= 0; j--) begin
                y = gf_mult(y, x) ^ l.coef[j];   // horner
            end
            if (y == '0 && r.count < `RS_T) begin
                r.loc[r.count] = sym_t'(i);
                r.count        = r.count + 3'd1;
            end
        end
        return r;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    task automatic start_scan(input lambda_t l, input chien_result_t exp);
        @(posedge clk);
        #1;
        lambda  = l;
        exp_res = exp;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start   = 1'b0;
    endtask

    task automatic run_scan(input lambda_t l, input chien_result_t exp);
        int seen;
        seen = done_count;
        start_scan(l, exp);
        wait (done_count != seen);
    endtask

    // locator built from k distinct known roots
    task automatic run_built();
        lambda_t       l;
        chien_result_t exp;
        logic [15:0]   used;
        int            k;
        int            n;
        int            p;
        k    = rand_bits(2) + 1;
        used = '0;
        n    = 0;
        while (n < k) begin
            p = rand_bits(4);
            if (!used[p]) begin
                used[p] = 1'b1;
                n++;
            end
        end
        l         = '0;
        l.coef[0] = 8'h01;
        exp.count = 3'(k);
        exp.loc   = {`RS_T{`RS_LOC_NONE}};
        n = 0;
        for (p = 0; p < `RS_N; p++) begin
            if (used[p]) begin
                l          = mul_linear(l, alpha_to(p + 1));
                exp.loc[n] = sym_t'(p);   // ascending by construction
                n++;
            end
        end
        run_scan(l, exp);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (start) begin
                since_start = 0;
                pending     = 1'b1;
            end else if (pending) begin
                since_start = since_start + 1;
            end
            check_equal(done, pending && since_start == DONE_AT, "done pulse position");
            if (done) begin
                for (int s = 0; s < `RS_T; s++) begin
                    check_equal(result.loc[s], exp_res.loc[s], $sformatf("loc slot %0d", s));
                end
                check_equal(result.count, exp_res.count, "root count");
                pending = 1'b0;
                done_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation ran too long");
        end
    end

    initial begin
        lambda_t       l;
        lambda_t       l2;
        chien_result_t exp;
        start          = 1'b0;
        lambda         = '0;
        lfsr_state     = 32'hac082ca8;
        exp_res        = '0;
        pending        = 1'b0;
        since_start    = 0;
        done_count     = 0;
        cycle_count    = 0;

        @(posedge rst_n);
        @(negedge clk);
        check_equal(done, 1'b0, "done after reset");
        check_equal(result.count, 3'd0, "count after reset");
        for (int s = 0; s < `RS_T; s++) begin
            check_equal(result.loc[s], `RS_LOC_NONE, $sformatf("slot %0d after reset", s));
        end

        // lambda = 1 has no roots
        l         = '0;
        l.coef[0] = 8'h01;
        exp.count = '0;
        exp.loc   = {`RS_T{`RS_LOC_NONE}};
        run_scan(l, exp);

        repeat (NUM_BUILT) run_built();

        repeat (NUM_RANDOM) begin
            for (int j = 0; j <= `RS_T; j++) begin
                l.coef[j] = sym_t'(rand_bits(8));
            end
            run_scan(l, chien_ref(l));
        end

        // every position is a root but only four fit
        l         = '0;
        exp.count = 3'd4;
        for (int s = 0; s < `RS_T; s++) begin
            exp.loc[s] = sym_t'(s);
        end
        run_scan(l, exp);

        // second start mid scan so only its done may appear
        for (int j = 0; j <= `RS_T; j++) begin
            l.coef[j]  = sym_t'(rand_bits(8));
            l2.coef[j] = sym_t'(rand_bits(8));
        end
        start_scan(l, chien_ref(l));
        repeat (5) @(posedge clk);
        run_scan(l2, chien_ref(l2));

        repeat (4) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release just after an edge, clear of the DUT sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== chien/chien_search.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_config.svh"

module chien_search (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  rs_pkg::lambda_t       lambda,
    output rs_pkg::chien_result_t result,
    output logic                  done
);
    import rs_pkg::*;

    sym_t             lambda0;   // constant term, no stepping needed
    sym_t [`RS_T-1:0] terms;     // terms[j-1] belongs to lambda_j
    logic             running;
    logic             step;

    always_ff @(posedge clk) begin
        if (start) begin
            lambda0 <= lambda.coef[0];
        end
    end

    // a start on a running scan reloads instead of stepping
    assign step = running & ~start;

    for (genvar j = 0; j < `RS_T; j++) begin : g_cell
        chien_cell #(
            .J       (j + 1),
            .ALPHA_J (alpha_pow(j + 1))
        ) cell_i (
            .clk   (clk),
            .rst_n (rst_n),
            .load  (start),
            .coef  (lambda.coef[j+1]),
            .step  (step),
            .term  (terms[j])
        );
    end

    chien_ctrl ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (start),
        .lambda0 (lambda0),
        .terms   (terms),
        .running (running),
        .result  (result),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== chien/chien_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_config.svh"

module chien_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load,
    input  rs_pkg::sym_t                  lambda0,
    input  rs_pkg::sym_t [`RS_T-1:0]      terms,
    output logic                          running,
    output rs_pkg::chien_result_t         result,
    output logic                          done
);
    import rs_pkg::*;

    localparam int IDX_BW  = $clog2(`RS_N);
    localparam int SLOT_BW = $clog2(`RS_T);

    logic [IDX_BW-1:0]  idx;        // position under test
    logic [SLOT_BW-1:0] slot;       // next free location slot
    sym_t               eval;       // lambda(alpha^(idx+1))
    logic               hit;
    logic               last;

    // sum of all terms
    always_comb begin
        eval = lambda0;
        for (int j = 0; j < `RS_T; j++) begin
            eval = eval ^ terms[j];
        end
    end

    assign slot = result.count[SLOT_BW-1:0];
    assign hit  = running && (eval == '0) && (result.count < 3'(`RS_T));   // full, drop the rest
    assign last = running && (idx == IDX_BW'(`RS_N-1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running      <= 1'b0;
            done         <= 1'b0;
            idx          <= '0;
            result.count <= '0;
            result.loc   <= {`RS_T{`RS_LOC_NONE}};
        end else begin
            done <= 1'b0;
            if (load) begin
                // restart, any scan in flight is abandoned
                running      <= 1'b1;
                idx          <= '0;
                result.count <= '0;
                result.loc   <= {`RS_T{`RS_LOC_NONE}};
            end else if (running) begin
                if (hit) begin
                    result.loc[slot] <= sym_t'(idx);
                    result.count     <= result.count + 3'd1;
                end
                if (last) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    a_done_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("chien_ctrl: done held two cycles");

    a_count_max : assert property (
        @(posedge clk) disable iff (!rst_n)
        result.count <= 3'(`RS_T)
    ) else $error("chien_ctrl: root count overflow");

    // done only closes a scan that was running
    a_done_after_run : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(running)
    ) else $error("chien_ctrl: done without a scan");

endmodule

`default_nettype wire

// ==== chien/chien_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

// one Chien term, lambda_j * alpha^(j*(i+1)) for the position i under test
module chien_cell #(
    parameter int           J       = 1,
    parameter rs_pkg::sym_t ALPHA_J = rs_pkg::alpha_pow(J)   // per-step constant
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         load,
    input  rs_pkg::sym_t coef,
    input  logic         step,
    output rs_pkg::sym_t term
);
    import rs_pkg::*;

    sym_t mul_in;
    sym_t mul_out;

    // load seeds with lambda_j * alpha^j, i.e. position 0
    assign mul_in = load ? coef : term;

    gf_mul mul_i (
        .a (mul_in),
        .b (ALPHA_J),
        .p (mul_out)
    );

    // payload only, meaningless until the first load
    always_ff @(posedge clk) begin
        if (load || step) begin
            term <= mul_out;
        end
    end

    // the top masks step while a new locator is loaded
    a_load_step_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && step)
    ) else $error("chien_cell J=%0d: load and step together", J);

endmodule

`default_nettype wire

// ==== design/gf_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_config.svh"

module gf_mul (
    input  rs_pkg::sym_t a,
    input  rs_pkg::sym_t b,
    output rs_pkg::sym_t p
);
    import rs_pkg::*;

    localparam logic [`RS_SYM_BW:0] POLY = `RS_GF_POLY;
    localparam sym_t RED = POLY[`RS_SYM_BW-1:0];   // low byte of the field polynomial

    sym_t [`RS_SYM_BW-1:0] shifted;   // a * x^k, already reduced
    sym_t [`RS_SYM_BW:0]   partial;   // running sum over b bits

    assign shifted[0] = a;
    assign partial[0] = '0;

    for (genvar k = 0; k < `RS_SYM_BW; k++) begin : g_stage
        // add a * x^k where b has a one
        assign partial[k+1] = b[k] ? (partial[k] ^ shifted[k]) : partial[k];

        if (k < `RS_SYM_BW-1) begin : g_shift
            assign shifted[k+1] = {shifted[k][`RS_SYM_BW-2:0], 1'b0}
                                ^ (RED & {`RS_SYM_BW{shifted[k][`RS_SYM_BW-1]}});
        end
    end

    assign p = partial[`RS_SYM_BW];

endmodule

`default_nettype wire

// ==== common/rs_pkg.sv ====
`default_nettype none

`include "rs_config.svh"

package rs_pkg;

    // one field element
    typedef logic [`RS_SYM_BW-1:0] sym_t;

    // error locator, coef[0] is lambda0
    typedef struct packed {
        sym_t [`RS_T:0] coef;
    } lambda_t;

    // loc[0] holds the lowest position found
    typedef struct packed {
        sym_t [`RS_T-1:0] loc;
        logic [2:0]       count;   // roots recorded, saturates at RS_T
    } chien_result_t;

    // alpha^k by repeated xtime, for elaboration-time constants
    function automatic sym_t alpha_pow(input int unsigned k);
        logic [`RS_SYM_BW:0] v;
        int unsigned         n;
        v = 1;
        for (n = 0; n < k; n++) begin
            v = v << 1;
            if (v[`RS_SYM_BW]) begin
                v = v ^ `RS_GF_POLY;   // fold x^8 back in
            end
        end
        return v[`RS_SYM_BW-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== common/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// RS(16,8) over GF(256)
`define RS_SYM_BW   8

// scanned symbol positions
`define RS_N        16

// correction capability, also the locator degree
`define RS_T        4

// x^8 + x^4 + x^3 + x^2 + 1
`define RS_GF_POLY  9'h11d

// marks an unused location slot
`define RS_LOC_NONE 8'hff

`endif
